/* bench/axil_iob_checker.sv */
`timescale 1ns/100ps
`include "axil_iob_consts.svh"
`default_nettype none

module axil_iob_checker
   import axil_pkg::*;
(
   input  wire         clk_i,
   input  wire         arst_n_i,
   input  axil_addr_t  axil_awaddr_i,
   input  wire         axil_awvalid_i,
   input  wire         axil_awready_i,
   input  axil_data_t  axil_wdata_i,
   input  axil_strb_t  axil_wstrb_i,
   input  wire         axil_wready_i,
   input  axil_resp_t  axil_bresp_i,
   input  wire         axil_bvalid_i,
   input  wire         axil_bready_i,
   input  axil_addr_t  axil_araddr_i,
   input  wire         axil_arvalid_i,
   input  wire         axil_arready_i,
   input  axil_data_t  axil_rdata_i,
   input  axil_resp_t  axil_rresp_i,
   input  wire         axil_rvalid_i,
   input  wire         axil_rready_i,
   output logic [31:0] err_cnt_o,
   output logic [31:0] wr_open_o,
   output logic [31:0] rd_open_o
);

   axil_data_t model [`RF_DEPTH];
   axil_data_t exp_q [$];
   axil_data_t last_rdata;
   logic       r_stalled;

   initial begin
      err_cnt_o  = '0;
      wr_open_o  = '0;
      rd_open_o  = '0;
      r_stalled  = 1'b0;
      last_rdata = '0;
   end

   always @(posedge clk_i) begin
      if (!arst_n_i) begin
         for (int i = 0; i < `RF_DEPTH; i++) begin
            model[i] = '0;
         end
         r_stalled = 1'b0;
      end else begin
         // W is taken in the same cycle as AW
         if (axil_wready_i != axil_awready_i) begin
            $display("Error wready: got 0x%h expected 0x%h", axil_wready_i,
                     axil_awready_i);
            err_cnt_o = err_cnt_o + 1;
         end
         // A read address offered in the same cycle holds the write back
         if (axil_awvalid_i && axil_awready_i && axil_arvalid_i) begin
            $display("write accepted while a read address was waiting");
            err_cnt_o = err_cnt_o + 1;
         end
         // Same-cycle read sees the value from before the write
         if (axil_arvalid_i && axil_arready_i) begin
            exp_q.push_back(model[axil_araddr_i[`RF_IDX_LSB +: `RF_IDX_W]]);
            rd_open_o = rd_open_o + 1;
         end
         if (axil_awvalid_i && axil_awready_i) begin
            for (int b = 0; b < `STRB_W; b++) begin
               if (axil_wstrb_i[b]) begin
                  model[axil_awaddr_i[`RF_IDX_LSB +: `RF_IDX_W]][8*b +: 8] =
                     axil_wdata_i[8*b +: 8];
               end
            end
            wr_open_o = wr_open_o + 1;
         end
         if (axil_bvalid_i && axil_bready_i) begin
            if (wr_open_o == 0) begin
               $display("write response without an accepted write");
               err_cnt_o = err_cnt_o + 1;
            end else begin
               wr_open_o = wr_open_o - 1;
            end
            if (axil_bresp_i != 2'b00) begin
               $display("Error bresp: got 0x%h expected 0x0", axil_bresp_i);
               err_cnt_o = err_cnt_o + 1;
            end
         end
         // rdata must not move while the host stalls
         if (r_stalled && axil_rdata_i != last_rdata) begin
            $display("Error rdata: got 0x%08h expected 0x%08h (stall)",
                     axil_rdata_i, last_rdata);
            err_cnt_o = err_cnt_o + 1;
         end
         if (axil_rvalid_i && axil_rready_i) begin
            if (exp_q.size() == 0) begin
               $display("read data beat without an accepted read");
               err_cnt_o = err_cnt_o + 1;
            end else begin
               if (axil_rdata_i != exp_q[0]) begin
                  $display("Error rdata: got 0x%08h expected 0x%08h",
                           axil_rdata_i, exp_q[0]);
                  err_cnt_o = err_cnt_o + 1;
               end
               void'(exp_q.pop_front());
               rd_open_o = rd_open_o - 1;
            end
            if (axil_rresp_i != 2'b00) begin
               $display("Error rresp: got 0x%h expected 0x0", axil_rresp_i);
               err_cnt_o = err_cnt_o + 1;
            end
         end
         r_stalled  = axil_rvalid_i && !axil_rready_i;
         last_rdata = axil_rdata_i;
      end
   end

endmodule

`default_nettype wire

/* bench/tb_axil_iob.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_axil_iob
   import axil_pkg::*;
;

   localparam int CYCLE_LIMIT = 300 * 20;

   logic        clk;
   logic        arst_n;
   axil_addr_t  awaddr;
   logic        awvalid;
   axil_data_t  wdata;
   axil_strb_t  wstrb;
   logic        wvalid;
   logic        bready;
   axil_addr_t  araddr;
   logic        arvalid;
   logic        rready;
   logic        awready;
   logic        wready;
   axil_resp_t  bresp;
   logic        bvalid;
   logic        arready;
   axil_data_t  rdata;
   axil_resp_t  rresp;
   logic        rvalid;
   logic [31:0] chk_errs;
   logic [31:0] wr_open;
   logic [31:0] rd_open;

   integer      seed = 32'h0c9da955;
   int          tb_errs = 0;
   int          errs_before = 0;
   int          tests_done = 0;
   int          cycles = 0;
   logic        stall_en = 1'b0;

   axil_iob_top UUT (
      .clk_i(clk), .arst_n_i(arst_n),
      .axil_awaddr_i(awaddr), .axil_awvalid_i(awvalid), .axil_awready_o(awready),
      .axil_wdata_i(wdata), .axil_wstrb_i(wstrb), .axil_wvalid_i(wvalid),
      .axil_wready_o(wready), .axil_bresp_o(bresp), .axil_bvalid_o(bvalid),
      .axil_bready_i(bready), .axil_araddr_i(araddr), .axil_arvalid_i(arvalid),
      .axil_arready_o(arready), .axil_rdata_o(rdata), .axil_rresp_o(rresp),
      .axil_rvalid_o(rvalid), .axil_rready_i(rready)
   );

   axil_iob_checker chk (
      .clk_i(clk), .arst_n_i(arst_n),
      .axil_awaddr_i(awaddr), .axil_awvalid_i(awvalid), .axil_awready_i(awready),
      .axil_wdata_i(wdata), .axil_wstrb_i(wstrb), .axil_wready_i(wready),
      .axil_bresp_i(bresp), .axil_bvalid_i(bvalid), .axil_bready_i(bready),
      .axil_araddr_i(araddr), .axil_arvalid_i(arvalid), .axil_arready_i(arready),
      .axil_rdata_i(rdata), .axil_rresp_i(rresp), .axil_rvalid_i(rvalid),
      .axil_rready_i(rready),
      .err_cnt_o(chk_errs), .wr_open_o(wr_open), .rd_open_o(rd_open)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] rand32();
      rand32 = $random(seed);
   endfunction

   // Response ready lines, randomly low while stalling is on
   always @(posedge clk) begin
      logic [31:0] r;
      r = rand32();
      bready <= stall_en ? r[0] : 1'b1;
      rready <= stall_en ? r[1] : 1'b1;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: transactions did not complete");
         $display("RESULT: FAIL");
         $finish;
      end
   end

   task automatic write_word(input axil_addr_t a, input axil_data_t d, input axil_strb_t s);
      awaddr  <= a;
      wdata   <= d;
      wstrb   <= s;
      awvalid <= 1'b1;
      wvalid  <= 1'b1;
      do @(posedge clk); while (!awready);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      do @(posedge clk); while (!(bvalid && bready));
   endtask

   task automatic read_word(input axil_addr_t a);
      araddr  <= a;
      arvalid <= 1'b1;
      do @(posedge clk); while (!arready);
      arvalid <= 1'b0;
      do @(posedge clk); while (!(rvalid && rready));
   endtask

   task automatic report_test(input string name);
      int now;
      now = tb_errs + int'(chk_errs);
      $display("%s: %0d errors", name, now - errs_before);
      errs_before = now;
      tests_done++;
   endtask

   initial begin
      logic [31:0] r;
      logic [31:0] d;
      arst_n = 1'b0;
      awaddr = '0;
      awvalid = 1'b0;
      wdata = '0;
      wstrb = '0;
      wvalid = 1'b0;
      bready = 1'b1;
      araddr = '0;
      arvalid = 1'b0;
      rready = 1'b1;
      repeat (2) @(posedge clk);
      arst_n <= 1'b1;
      @(posedge clk);

      if (bvalid !== 1'b0) begin
         $display("Error bvalid: got 0x%h expected 0x0", bvalid);
         tb_errs++;
      end
      if (rvalid !== 1'b0) begin
         $display("Error rvalid: got 0x%h expected 0x0", rvalid);
         tb_errs++;
      end
      for (int i = 0; i < 16; i++) read_word(axil_addr_t'(i * 4));
      report_test("reset");

      for (int i = 0; i < 20; i++) begin
         r = rand32();
         write_word(r[7:0], rand32(), 4'hf);
         read_word(r[7:0]);
      end
      report_test("full-word writes");

      for (int i = 0; i < 20; i++) begin
         r = rand32();
         // Every fifth write carries no strobes at all
         write_word(r[7:0], rand32(), (i % 5 == 0) ? 4'h0 : r[11:8]);
         read_word(r[7:0]);
      end
      report_test("partial strobes");

      for (int i = 0; i < 8; i++) begin
         r = rand32();
         d = rand32();
         write_word({r[7:6], r[5:2], r[1:0]}, d, 4'hf);
         read_word({r[15:14], r[5:2], r[9:8]});
      end
      report_test("aliasing");

      stall_en <= 1'b1;
      for (int i = 0; i < 40; i++) begin
         r = rand32();
         if (r[31]) begin
            write_word(r[7:0], rand32(), r[11:8]);
         end else begin
            read_word(r[7:0]);
         end
      end
      report_test("back-pressure");

      for (int i = 0; i < 20; i++) begin
         r = rand32();
         d = rand32();
         fork
            write_word(r[7:0], d, 4'hf);
            read_word(r[7:0]);
         join
      end
      stall_en <= 1'b0;
      repeat (4) @(posedge clk);
      if (wr_open != 0 || rd_open != 0) begin
         $display("transactions left without a response at the end");
         tb_errs++;
      end
      report_test("simultaneous requests");

      $display("tests: %0d, errors: %0d", tests_done, tb_errs + int'(chk_errs));
      if (tb_errs + int'(chk_errs) == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+include
hdl/axil_pkg.sv
hdl/iob_pkg.sv
hdl/axil2iob.sv
hdl/iob_regfile.sv
hdl/axil_iob_top.sv
bench/axil_iob_checker.sv
bench/tb_axil_iob.sv

/* hdl/axil2iob.sv */
`timescale 1ns/100ps
`default_nettype none

module axil2iob
   import axil_pkg::*;
   import iob_pkg::*;
(
   input  wire        clk_i,
   input  wire        arst_n_i,

   // AXI4-Lite slave
   input  axil_addr_t axil_awaddr_i,
   input  wire        axil_awvalid_i,
   output logic       axil_awready_o,
   input  axil_data_t axil_wdata_i,
   input  axil_strb_t axil_wstrb_i,
   input  wire        axil_wvalid_i,
   output logic       axil_wready_o,
   output axil_resp_t axil_bresp_o,
   output logic       axil_bvalid_o,
   input  wire        axil_bready_i,
   input  axil_addr_t axil_araddr_i,
   input  wire        axil_arvalid_i,
   output logic       axil_arready_o,
   output axil_data_t axil_rdata_o,
   output axil_resp_t axil_rresp_o,
   output logic       axil_rvalid_o,
   input  wire        axil_rready_i,

   // IOb master
   output logic       iob_avalid_o,
   output iob_addr_t  iob_addr_o,
   output iob_data_t  iob_wdata_o,
   output iob_strb_t  iob_wstrb_o,
   input  wire        iob_ready_i,
   input  wire        iob_rvalid_i,
   input  iob_data_t  iob_rdata_i
);

   logic       rd_req;
   logic       wr_req;
   logic       wr_has_strb;
   logic       rd_acc;
   logic       wr_acc;

   logic       bvalid_q;
   logic       rvalid_q;
   logic       rd_pend_q;
   axil_data_t rdata_q;

   // Read side may start when nothing of a previous read is left
   assign rd_req = axil_arvalid_i & ~rvalid_q & ~rd_pend_q;

   // Writes yield to any offered read address
   assign wr_req = axil_awvalid_i & axil_wvalid_i & ~bvalid_q & ~rd_pend_q
                   & ~axil_arvalid_i;

   assign wr_has_strb = |axil_wstrb_i;

   assign rd_acc = rd_req & iob_ready_i;

   // An empty strobe write never reaches the bank, so it skips the ready wait
   assign wr_acc = wr_req & (~wr_has_strb | iob_ready_i);

   // IOb request, one access at a time
   assign iob_avalid_o = rd_req | (wr_req & wr_has_strb);
   assign iob_addr_o   = rd_req ? axil_araddr_i : axil_awaddr_i;
   assign iob_wdata_o  = axil_wdata_i;
   assign iob_wstrb_o  = rd_req ? '0 : axil_wstrb_i;

   // AW and W are taken together
   assign axil_awready_o = wr_acc;
   assign axil_wready_o  = wr_acc;
   assign axil_arready_o = rd_acc;

   // Always OKAY
   assign axil_bresp_o = 2'b00;
   assign axil_rresp_o = 2'b00;

   assign axil_bvalid_o = bvalid_q;
   assign axil_rvalid_o = rvalid_q;
   assign axil_rdata_o  = rdata_q;

   // Write response, held until the host takes it
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         bvalid_q <= 1'b0;
      end else if (wr_acc) begin
         bvalid_q <= 1'b1;
      end else if (axil_bready_i) begin
         bvalid_q <= 1'b0;
      end
   end

   // Read in flight between accept and iob_rvalid
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rd_pend_q <= 1'b0;
      end else if (rd_acc) begin
         rd_pend_q <= 1'b1;
      end else if (iob_rvalid_i) begin
         rd_pend_q <= 1'b0;
      end
   end

   // rvalid follows iob_rvalid by a cycle and waits for rready
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rvalid_q <= 1'b0;
      end else if (iob_rvalid_i) begin
         rvalid_q <= 1'b1;
      end else if (axil_rready_i) begin
         rvalid_q <= 1'b0;
      end
   end

   // Only the returning read updates the data, so it holds under stall
   always_ff @(posedge clk_i) begin
      if (iob_rvalid_i) begin
         rdata_q <= iob_rdata_i;
      end
   end

endmodule

`default_nettype wire

/* hdl/axil_iob_top.sv */
`timescale 1ns/100ps
`default_nettype none

module axil_iob_top
   import axil_pkg::*;
   import iob_pkg::*;
(
   input  wire        clk_i,
   input  wire        arst_n_i,

   input  axil_addr_t axil_awaddr_i,
   input  wire        axil_awvalid_i,
   output logic       axil_awready_o,
   input  axil_data_t axil_wdata_i,
   input  axil_strb_t axil_wstrb_i,
   input  wire        axil_wvalid_i,
   output logic       axil_wready_o,
   output axil_resp_t axil_bresp_o,
   output logic       axil_bvalid_o,
   input  wire        axil_bready_i,
   input  axil_addr_t axil_araddr_i,
   input  wire        axil_arvalid_i,
   output logic       axil_arready_o,
   output axil_data_t axil_rdata_o,
   output axil_resp_t axil_rresp_o,
   output logic       axil_rvalid_o,
   input  wire        axil_rready_i
);

   // Internal IOb bus
   logic      iob_avalid;
   iob_addr_t iob_addr;
   iob_data_t iob_wdata;
   iob_strb_t iob_wstrb;
   logic      iob_ready;
   logic      iob_rvalid;
   iob_data_t iob_rdata;

   axil2iob u_axil2iob (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .axil_awaddr_i  (axil_awaddr_i),
      .axil_awvalid_i (axil_awvalid_i),
      .axil_awready_o (axil_awready_o),
      .axil_wdata_i   (axil_wdata_i),
      .axil_wstrb_i   (axil_wstrb_i),
      .axil_wvalid_i  (axil_wvalid_i),
      .axil_wready_o  (axil_wready_o),
      .axil_bresp_o   (axil_bresp_o),
      .axil_bvalid_o  (axil_bvalid_o),
      .axil_bready_i  (axil_bready_i),
      .axil_araddr_i  (axil_araddr_i),
      .axil_arvalid_i (axil_arvalid_i),
      .axil_arready_o (axil_arready_o),
      .axil_rdata_o   (axil_rdata_o),
      .axil_rresp_o   (axil_rresp_o),
      .axil_rvalid_o  (axil_rvalid_o),
      .axil_rready_i  (axil_rready_i),
      .iob_avalid_o   (iob_avalid),
      .iob_addr_o     (iob_addr),
      .iob_wdata_o    (iob_wdata),
      .iob_wstrb_o    (iob_wstrb),
      .iob_ready_i    (iob_ready),
      .iob_rvalid_i   (iob_rvalid),
      .iob_rdata_i    (iob_rdata)
   );

   iob_regfile u_iob_regfile (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .iob_avalid_i (iob_avalid),
      .iob_addr_i   (iob_addr),
      .iob_wdata_i  (iob_wdata),
      .iob_wstrb_i  (iob_wstrb),
      .iob_ready_o  (iob_ready),
      .iob_rvalid_o (iob_rvalid),
      .iob_rdata_o  (iob_rdata)
   );

endmodule

`default_nettype wire

/* hdl/axil_pkg.sv */
`include "axil_iob_consts.svh"
`default_nettype none

// Vector types seen on the AXI4-Lite slave port
package axil_pkg;

   // Byte address on AW and AR
   typedef logic [`AXIL_ADDR_W-1:0] axil_addr_t;

   // Write and read data
   typedef logic [`DATA_W-1:0] axil_data_t;

   // Byte lane enables on W
   typedef logic [`STRB_W-1:0] axil_strb_t;

   // BRESP and RRESP, only OKAY (2'b00) is ever returned here
   typedef logic [1:0] axil_resp_t;

endpackage

`default_nettype wire

/* hdl/iob_pkg.sv */
`include "axil_iob_consts.svh"
`default_nettype none

// Vector types of the internal IOb bus and its register bank
package iob_pkg;

   // IOb byte address, same width as the AXI side
   typedef logic [`AXIL_ADDR_W-1:0] iob_addr_t;

   typedef logic [`DATA_W-1:0] iob_data_t;

   // Write strobes, all zero marks a read access
   typedef logic [`STRB_W-1:0] iob_strb_t;

   // Register bank word index
   typedef logic [`RF_IDX_W-1:0] rf_idx_t;

   // Register bank FSM, one busy cycle follows every write
   typedef enum logic {
      rf_idle,
      rf_wr_busy
   } rf_state_t;

endpackage

`default_nettype wire

/* hdl/iob_regfile.sv */
`timescale 1ns/100ps
`include "axil_iob_consts.svh"
`default_nettype none

module iob_regfile
   import iob_pkg::*;
(
   input  wire       clk_i,
   input  wire       arst_n_i,

   // IOb slave
   input  wire       iob_avalid_i,
   input  iob_addr_t iob_addr_i,
   input  iob_data_t iob_wdata_i,
   input  iob_strb_t iob_wstrb_i,
   output logic      iob_ready_o,
   output logic      iob_rvalid_o,
   output iob_data_t iob_rdata_o
);

   rf_state_t state_q;
   rf_state_t state_d;

   iob_data_t regs_q [`RF_DEPTH];

   rf_idx_t   idx;
   logic      acc;
   logic      is_write;
   logic      wr_acc;
   logic      rd_acc;

   logic      rvalid_q;
   iob_data_t rdata_q;

   // Word index only, upper address bits alias
   assign idx = iob_addr_i[`RF_IDX_LSB +: `RF_IDX_W];

   assign iob_ready_o = (state_q == rf_idle);

   assign acc      = iob_avalid_i & iob_ready_o;
   assign is_write = |iob_wstrb_i;
   assign wr_acc   = acc & is_write;
   assign rd_acc   = acc & ~is_write;

   // Busy for exactly one cycle after each write
   always_comb begin
      state_d = state_q;
      case (state_q)
         rf_idle: begin
            if (wr_acc) begin
               state_d = rf_wr_busy;
            end
         end
         rf_wr_busy: begin
            state_d = rf_idle;
         end
         default: begin
            state_d = rf_idle;
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= rf_idle;
      end else begin
         state_q <= state_d;
      end
   end

   // Register array, byte lanes written under their strobe
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 0; i < `RF_DEPTH; i++) begin
            regs_q[i] <= '0;
         end
      end else if (wr_acc) begin
         for (int b = 0; b < `STRB_W; b++) begin
            if (iob_wstrb_i[b]) begin
               regs_q[idx][8*b +: 8] <= iob_wdata_i[8*b +: 8];
            end
         end
      end
   end

   // One cycle pulse per accepted read
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= rd_acc;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_acc) begin
         rdata_q <= regs_q[idx];
      end
   end

   assign iob_rvalid_o = rvalid_q;
   assign iob_rdata_o  = rdata_q;

endmodule

`default_nettype wire

/* include/axil_iob_consts.svh */
`ifndef AXIL_IOB_CONSTS_SVH
`define AXIL_IOB_CONSTS_SVH

// AXI4-Lite byte address width, shared with the IOb side
`define AXIL_ADDR_W 8

// Data path width for both buses
`define DATA_W 32

// One strobe bit per byte lane
`define STRB_W 4

// Register bank size
`define RF_DEPTH 16

// Word index into the register bank, taken from address bits 5:2
`define RF_IDX_W 4

// Lowest address bit above the byte offset
`define RF_IDX_LSB 2

`endif

/* run.sh */
#!/bin/bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tb_axil_iob -o sim_tb \
   && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "^RESULT: PASS$" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
